// File: acsArray.sv
/* ACS array: 20 units wired along the trellis, sharing one normalize
   request built from every unit's overflow flag */
`timescale 1ns/1ns

module acsArray #(
   parameter int branchWidth = vitMetricPkg::branchWidth
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    symEn,
   input  vitMetricPkg::branchVecT branch1Real,
   input  vitMetricPkg::branchVecT branch0Real,
   input  vitMetricPkg::rotVecT    branch1Imag,
   input  vitMetricPkg::rotVecT    branch0Imag,
   output vitMetricPkg::metricVecT pathMetric,
   output vitTrellisPkg::selVecT   sel,
   output vitMetricPkg::rotVecT    stateImag
);
   import vitTrellisPkg::*;
   import vitMetricPkg::*;

   logic [numStates-1:0] nearOverflow;
   logic                 normalize;

   // any state near the top rescales every state on the next symbol
   assign normalize = |nearOverflow;

   // ----------------------------------------
   // one unit per state
   // ----------------------------------------
   for (genvar s = 0; s < numStates; s++) begin : gState
      localparam int p1 = pred1(s);   // branch 1 source state
      localparam int p0 = pred0(s);   // branch 0 source state

      acsUnit #(
         .branchWidth (branchWidth)
      ) uAcs (
         .clk          (clk),
         .reset        (reset),
         .symEn        (symEn),
         .pred1Metric  (pathMetric[p1]),
         .pred0Metric  (pathMetric[p0]),
         .branch1      (branch1Real[p1]),
         .branch0      (branch0Real[p0]),
         .imag1        (branch1Imag[p1]),
         .imag0        (branch0Imag[p0]),
         .normalizeIn  (normalize),
         .metric       (pathMetric[s]),
         .selOut       (sel[s]),
         .stateImag    (stateImag[s]),
         .nearOverflow (nearOverflow[s])
      );
   end

endmodule

// File: acsUnit.sv
/* Add-compare-select for one trellis state, keeping the better of the
   two incoming paths and rescaling when the array asks for it */
`timescale 1ns/1ns

module acsUnit #(
   parameter int branchWidth = vitMetricPkg::branchWidth
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 symEn,
   input  vitMetricPkg::metricT pred1Metric,
   input  vitMetricPkg::metricT pred0Metric,
   input  vitMetricPkg::branchT branch1,
   input  vitMetricPkg::branchT branch0,
   input  vitMetricPkg::rotT    imag1,
   input  vitMetricPkg::rotT    imag0,
   input  logic                 normalizeIn,
   output vitMetricPkg::metricT metric,
   output logic                 selOut,
   output vitMetricPkg::rotT    stateImag,
   output logic                 nearOverflow
);
   import vitMetricPkg::*;

   localparam int metricWidth = $bits(metricT);
   localparam int guardBits   = metricWidth - branchWidth;

   metricT sum1;
   metricT sum0;
   metricT bestSum;
   logic   pick1;

   // ----------------------------------------
   // add and compare
   // ----------------------------------------
   assign sum1    = pred1Metric + {{guardBits{1'b0}}, branch1};
   assign sum0    = pred0Metric + {{guardBits{1'b0}}, branch0};
   assign pick1   = (sum1 >= sum0);          // tie goes to branch 1
   assign bestSum = pick1 ? sum1 : sum0;

   // select and store
   always_ff @(posedge clk) begin
      if (reset) begin
         metric    <= '0;
         selOut    <= 1'b0;
         stateImag <= '0;
      end else if (symEn) begin
         if (normalizeIn)
            metric <= {1'b0, bestSum[metricWidth-2:0]};   // all states drop msb together
         else
            metric <= bestSum;
         selOut    <= pick1;
         stateImag <= pick1 ? imag1 : imag0;   // imag part rides with the survivor
      end
   end

   assign nearOverflow = metric[metricWidth-1];

endmodule

// File: all.f
vitTrellisPkg.sv
vitMetricPkg.sv
acsUnit.sv
acsArray.sv
symbolDelay.sv
maxMetric.sv
errorSelect.sv
viterbiTop.sv
tbClock.sv
viterbiChk.sv
viterbiTb.sv

// File: errorSelect.sv
/* Decision and phase error pick: reads the delayed selects and
   imaginary parts at the best state, phase error every other symbol */
`timescale 1ns/1ns

module errorSelect #(
   parameter int rotWidth = vitMetricPkg::rotWidth
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    indexValid,
   input  vitTrellisPkg::stateIdxT index,
   input  vitTrellisPkg::selVecT   selDly,
   input  vitMetricPkg::rotVecT    imagDly,
   output logic                    decision,
   output logic                    decisionValid,
   output logic [rotWidth-1:0]     phaseError,
   output logic                    phErrValid
);
   import vitTrellisPkg::*;

   stateIdxT evenIdx;
   logic     phaseTurn;     // high on symbols that update the phase error

   // even member of the best state's pair
   assign evenIdx = {index[$bits(stateIdxT)-1:1], 1'b0};

   // ----------------------------------------
   // decision path
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (indexValid)
         decision <= selDly[index];   // predecessor choice, two symbols back
   end

   // ----------------------------------------
   // strobes and phase error
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         decisionValid <= 1'b0;
         phErrValid    <= 1'b0;
         phaseTurn     <= 1'b1;   // first symbol carries a phase error
         phaseError    <= '0;
      end else begin
         decisionValid <= indexValid;
         phErrValid    <= indexValid & phaseTurn;
         if (indexValid) begin
            phaseTurn <= ~phaseTurn;
            if (phaseTurn)
               phaseError <= imagDly[evenIdx];
         end
      end
   end

endmodule

// File: maxMetric.sv
/* Best-state search over all path metrics, registered one cycle
   after the symbol strobe with a matching valid pulse */
`timescale 1ns/1ns

module maxMetric (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    symEn,
   input  vitMetricPkg::metricVecT pathMetric,
   output vitTrellisPkg::stateIdxT index,
   output logic                    indexValid
);
   import vitTrellisPkg::*;
   import vitMetricPkg::*;

   metricT   bestMetric;
   stateIdxT bestIdx;
   logic     captureEn;

   // ----------------------------------------
   // linear search, strict compare so the lowest state keeps a tie
   // ----------------------------------------
   always_comb begin
      bestMetric = pathMetric[0];
      bestIdx    = '0;
      for (int s = 1; s < numStates; s++) begin
         if (pathMetric[s] > bestMetric) begin
            bestMetric = pathMetric[s];
            bestIdx    = stateIdxT'(s);
         end
      end
   end

   // metrics settle the cycle after symEn
   always_ff @(posedge clk) begin
      if (reset) begin
         captureEn  <= 1'b0;
         index      <= '0;
         indexValid <= 1'b0;
      end else begin
         captureEn  <= symEn;
         indexValid <= captureEn;
         if (captureEn)
            index <= bestIdx;
      end
   end

endmodule

// File: run.sh
#!/bin/sh
# build and run the Viterbi testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module viterbiTb -f all.f -o viterbiSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/viterbiSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
   exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0

// File: symbolDelay.sv
/* Symbol-rate delay line for any payload, advancing one stage per
   symbol strobe */
`timescale 1ns/1ns

module symbolDelay #(
   parameter type payloadT = logic,
   parameter int  depth    = 2
) (
   input  logic    clk,
   input  logic    reset,
   input  logic    symEn,
   input  payloadT din,
   output payloadT dout
);

   payloadT stage [depth];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < depth; i++)
            stage[i] <= '0;
      end else if (symEn) begin
         stage[0] <= din;
         for (int i = 1; i < depth; i++)
            stage[i] <= stage[i-1];   // shift one symbol
      end
   end

   assign dout = stage[depth-1];

endmodule

// File: tbClock.sv
/* Testbench clock and power-on reset: free-running clock, reset held
   for a fixed number of cycles */
`timescale 1ns/1ns

module tbClock #(
   parameter int periodNs    = 8,
   parameter int resetCycles = 3
) (
   output logic clk,
   output logic reset
);

   initial clk = 1'b0;
   always #(periodNs / 2) clk = ~clk;

   initial begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;   // released on a falling edge like all stimulus
   end

endmodule

// File: vitMetricPkg.sv
/*
 * Metric arithmetic of the detector: branch, path metric and
 * imaginary widths with the per-state vector types built on them.
 */
package vitMetricPkg;

   localparam int branchWidth = 8;
   localparam int metricGuard = 4;     // headroom above one branch
   localparam int rotWidth    = 10;

   typedef logic [branchWidth-1:0]             branchT;
   typedef logic [branchWidth+metricGuard-1:0] metricT;   // unsigned
   typedef logic [rotWidth-1:0]                rotT;

   // ----------------------------------------
   // one entry per trellis state
   // ----------------------------------------
   typedef branchT [vitTrellisPkg::numStates-1:0] branchVecT;
   typedef metricT [vitTrellisPkg::numStates-1:0] metricVecT;
   typedef rotT    [vitTrellisPkg::numStates-1:0] rotVecT;

endpackage

// File: vitTrellisPkg.sv
/*
 * Trellis description of the 20-state detector: state count, index and
 * select types, and the branch predecessor rules.
 */
package vitTrellisPkg;

   localparam int numStates = 20;

   typedef logic [4:0] stateIdxT;

   // one survivor select bit per state, bit s belongs to state s
   typedef logic [numStates-1:0] selVecT;

   // ----------------------------------------
   // predecessor rules
   // ----------------------------------------
   localparam int pred1Offset = 13;
   localparam int pred0Offset = 7;

   // state reached on branch 1 comes from here
   function automatic int pred1(input int state);
      return (state + pred1Offset) % numStates;
   endfunction

   // and on branch 0 from here
   function automatic int pred0(input int state);
      return (state + pred0Offset) % numStates;
   endfunction

endpackage

// File: viterbiChk.sv
/* Protocol checks on the detector outputs: strobe shapes and the
   best-state index range */
`timescale 1ns/1ns

module viterbiChk (
   input logic                    clk,
   input logic                    reset,
   input logic                    decisionValid,
   input logic                    phErrValid,
   input vitTrellisPkg::stateIdxT index
);
   import vitTrellisPkg::*;

   // decision strobe lasts one cycle
   decisionPulse: assert property (@(posedge clk) disable iff (reset)
      decisionValid |=> !decisionValid)
      else $error("decisionValid stayed high for more than one cycle");

   phErrWithDecision: assert property (@(posedge clk) disable iff (reset)
      phErrValid |-> decisionValid)
      else $error("phErrValid came without decisionValid");

   indexRange: assert property (@(posedge clk) disable iff (reset)
      index < numStates)
      else $error("best-state index out of range");

endmodule

bind viterbiTop viterbiChk uChk (
   .clk           (clk),
   .reset         (reset),
   .decisionValid (decisionValid),
   .phErrValid    (phErrValid),
   .index         (index)
);

// File: viterbiTb.sv
/* Testbench for the Viterbi survivor and error path: reads symbols
   from the testdata file, drives them and checks every decision */
`timescale 1ns/1ns

module viterbiTb;
   import vitTrellisPkg::*;
   import vitMetricPkg::*;

   localparam int timeoutCycles = 40;

   logic                                      clk;
   logic                                      rstGen;
   logic                                      restart;
   logic                                      reset;
   logic                                      symEn;
   logic [numStates-1:0][branchWidth-1:0]     branch1Real;
   logic [numStates-1:0][branchWidth-1:0]     branch0Real;
   logic [numStates-1:0][rotWidth-1:0]        branch1Imag;
   logic [numStates-1:0][rotWidth-1:0]        branch0Imag;
   stateIdxT                                  index;
   logic                                      decision;
   logic                                      decisionValid;
   logic [rotWidth-1:0]                       phaseError;
   logic                                      phErrValid;

   int errors = 0;
   int checks = 0;

   tbClock #(.periodNs(8), .resetCycles(3)) uClock (.clk(clk), .reset(rstGen));

   assign reset = rstGen | restart;   // restart gives each test a clean trellis

   viterbiTop #(
      .branchWidth (branchWidth),
      .rotWidth    (rotWidth)
   ) i_viterbiTop (
      .clk           (clk),
      .reset         (reset),
      .symEn         (symEn),
      .branch1Real   (branch1Real),
      .branch0Real   (branch0Real),
      .branch1Imag   (branch1Imag),
      .branch0Imag   (branch0Imag),
      .index         (index),
      .decision      (decision),
      .decisionValid (decisionValid),
      .phaseError    (phaseError),
      .phErrValid    (phErrValid)
   );

   task automatic checkValue(input string testName, input string field,
                             input int expected, input int actual);
      checks++;
      if (expected != actual) begin
         errors++;
         $display("[ERROR] %s %s: expected %0d, actual %0d", testName, field, expected, actual);
      end
   endtask

   // every port at its base, one real port raised, imag port k at base plus k
   task automatic applyPorts(input int f, input int br, input int raise, input int b1r,
                             input int b0r, input int b1i, input int b0i);
      for (int k = 0; k < numStates; k++) begin
         branch1Real[k] = branchWidth'(b1r);
         branch0Real[k] = branchWidth'(b0r);
         branch1Imag[k] = rotWidth'(b1i + k);
         branch0Imag[k] = rotWidth'(b0i + k);
      end
      if (br == 1)
         branch1Real[f] = branchWidth'(b1r + raise);
      else
         branch0Real[f] = branchWidth'(b0r + raise);
   endtask

   task automatic restartDut();
      @(negedge clk);
      restart = 1'b1;
      repeat (2) @(negedge clk);
      restart = 1'b0;
      repeat (2) @(negedge clk);
   endtask

   // one symbol strobe, then wait for the decision
   task automatic sendSymbol(output bit timedOut);
      int waitCount;
      waitCount = 0;
      @(negedge clk);
      symEn = 1'b1;
      @(negedge clk);
      symEn = 1'b0;
      while (!decisionValid && waitCount < timeoutCycles) begin
         @(negedge clk);
         waitCount++;
      end
      timedOut = !decisionValid;
   endtask

   initial begin
      int    fd;
      int    fields;
      int    rst, f, br, raise, b1r, b0r, b1i, b0i;
      int    symCount;
      int    waitCount;
      bit    timedOut;
      bit    aborted;
      string line;
      string testName;
      string expIdx, expDec, expPh;

      symEn    = 1'b0;
      restart  = 1'b0;
      symCount = 0;
      aborted  = 1'b0;
      applyPorts(0, 1, 0, 0, 0, 0, 0);

      // wait out the power-on reset
      waitCount = 0;
      while (rstGen !== 1'b0 && waitCount < timeoutCycles) begin
         @(negedge clk);
         waitCount++;
      end
      if (rstGen !== 1'b0) begin
         $display("power-on reset was never released");
         aborted = 1'b1;
      end

      fd = $fopen("viterbiTestdata.txt", "r");
      if (fd == 0) begin
         $display("could not open viterbiTestdata.txt");
         aborted = 1'b1;
      end

      while (!aborted && !$feof(fd)) begin
         line = "";
         fields = $fgets(line, fd);
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d %s %s %s", testName, rst, f, br,
                          raise, b1r, b0r, b1i, b0i, expIdx, expDec, expPh);
         if (fields != 12)
            continue;
         if (rst != 0) begin
            restartDut();
            symCount = 0;
         end
         applyPorts(f, br, raise, b1r, b0r, b1i, b0i);
         sendSymbol(timedOut);
         if (timedOut) begin
            $display("timeout waiting for decisionValid in test %s", testName);
            aborted = 1'b1;
         end else begin
            symCount++;
            if (expIdx != "x")
               checkValue(testName, "index", expIdx.atoi(), int'(index));
            if (expDec != "x")
               checkValue(testName, "decision", expDec.atoi(), int'(decision));
            if (expPh != "x")
               checkValue(testName, "phaseError", expPh.atoi(), int'(phaseError));
            checkValue(testName, "phErrValid", symCount % 2, int'(phErrValid));   // odd symbols
            repeat (2) @(negedge clk);
         end
      end
      if (fd != 0)
         $fclose(fd);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0 && !aborted) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: viterbiTestdata.txt
# name rst f br raise b1Real b0Real b1Imag b0Imag | expected index decision phaseError (x = any)
# rst restarts the DUT, br is the favored branch at port f, raise is added to that real port
equal 1 0 1 0 10 10 100 300 0 0 0
equal 0 0 1 0 10 10 100 300 0 0 0
equal 0 0 1 0 10 10 100 300 0 1 113
equal 0 0 1 0 10 10 100 300 0 1 113
fav1 1 3 1 4 10 10 100 300 10 0 0
fav1 0 3 1 4 10 10 100 300 3 0 0
fav1 0 3 1 4 10 10 100 300 10 1 103
fav1 0 3 1 4 10 10 100 300 3 0 103
fav1 0 3 1 4 10 10 100 300 10 1 103
fav1 0 3 1 4 10 10 100 300 3 0 103
fav0 1 3 0 4 10 10 100 300 16 0 0
fav0 0 3 0 4 10 10 100 300 3 0 0
fav0 0 3 0 4 10 10 100 300 16 0 303
fav0 0 3 0 4 10 10 100 300 3 1 303
fav0 0 3 0 4 10 10 100 300 16 0 303
fav0 0 3 0 4 10 10 100 300 3 1 303
norm 1 3 1 4 200 200 100 300 10 0 0
norm 0 3 1 4 200 200 100 300 3 0 0
norm 0 3 1 4 200 200 100 300 10 1 103
norm 0 3 1 4 200 200 100 300 3 0 103
norm 0 3 1 4 200 200 100 300 10 1 103
norm 0 3 1 4 200 200 100 300 3 0 103
norm 0 3 1 4 200 200 100 300 10 1 103
norm 0 3 1 4 200 200 100 300 3 0 103
norm 0 3 1 4 200 200 100 300 10 1 103
norm 0 3 1 4 200 200 100 300 3 0 103
norm 0 3 1 4 200 200 100 300 10 1 103
norm 0 3 1 4 200 200 100 300 3 0 103
norm 0 3 1 4 200 200 100 300 10 1 103
norm 0 3 1 4 200 200 100 300 3 0 103

// File: viterbiTop.sv
/* Viterbi survivor and error path: ACS array, select and imaginary
   delay lines, best-state search and decision / phase error output */
`timescale 1ns/1ns

module viterbiTop #(
   parameter int branchWidth = vitMetricPkg::branchWidth,
   parameter int rotWidth    = vitMetricPkg::rotWidth
) (
   input  logic                                              clk,
   input  logic                                              reset,
   input  logic                                              symEn,
   input  logic [vitTrellisPkg::numStates-1:0][branchWidth-1:0] branch1Real,
   input  logic [vitTrellisPkg::numStates-1:0][branchWidth-1:0] branch0Real,
   input  logic [vitTrellisPkg::numStates-1:0][rotWidth-1:0]    branch1Imag,
   input  logic [vitTrellisPkg::numStates-1:0][rotWidth-1:0]    branch0Imag,
   output vitTrellisPkg::stateIdxT                           index,
   output logic                                              decision,
   output logic                                              decisionValid,
   output logic [rotWidth-1:0]                               phaseError,
   output logic                                              phErrValid
);
   import vitTrellisPkg::*;
   import vitMetricPkg::*;

   localparam int selectLag = 2;   // symbols between ACS output and error pick

   metricVecT pathMetric;
   selVecT    sel;
   selVecT    selDly;
   rotVecT    stateImag;
   rotVecT    imagDly;
   logic      indexValid;

   // ----------------------------------------
   // metric update
   // ----------------------------------------
   acsArray #(
      .branchWidth (branchWidth)
   ) uAcsArray (
      .clk         (clk),
      .reset       (reset),
      .symEn       (symEn),
      .branch1Real (branch1Real),
      .branch0Real (branch0Real),
      .branch1Imag (branch1Imag),
      .branch0Imag (branch0Imag),
      .pathMetric  (pathMetric),
      .sel         (sel),
      .stateImag   (stateImag)
   );

   // survivor history
   symbolDelay #(
      .payloadT (selVecT),
      .depth    (selectLag)
   ) uSelDelay (
      .clk   (clk),
      .reset (reset),
      .symEn (symEn),
      .din   (sel),
      .dout  (selDly)
   );

   symbolDelay #(
      .payloadT (rotVecT),
      .depth    (selectLag)
   ) uImagDelay (
      .clk   (clk),
      .reset (reset),
      .symEn (symEn),
      .din   (stateImag),
      .dout  (imagDly)
   );

   // ----------------------------------------
   // best state and outputs
   // ----------------------------------------
   maxMetric uMaxMetric (
      .clk        (clk),
      .reset      (reset),
      .symEn      (symEn),
      .pathMetric (pathMetric),
      .index      (index),
      .indexValid (indexValid)
   );

   errorSelect #(
      .rotWidth (rotWidth)
   ) uErrorSelect (
      .clk           (clk),
      .reset         (reset),
      .indexValid    (indexValid),
      .index         (index),
      .selDly        (selDly),
      .imagDly       (imagDly),
      .decision      (decision),
      .decisionValid (decisionValid),
      .phaseError    (phaseError),
      .phErrValid    (phErrValid)
   );

endmodule
